// File: mips_pkg.sv
`default_nettype none

package mips_pkg;

    // datapath and address width
    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    localparam int num_regs    = 32;
    localparam int queue_depth = 4;

    // primary opcodes of the kept instructions
    localparam logic [5:0] op_special = 6'b00_0000;
    localparam logic [5:0] op_addi    = 6'b00_1000;
    localparam logic [5:0] op_addiu   = 6'b00_1001;
    localparam logic [5:0] op_slti    = 6'b00_1010;
    localparam logic [5:0] op_sltiu   = 6'b00_1011;
    localparam logic [5:0] op_andi    = 6'b00_1100;
    localparam logic [5:0] op_ori     = 6'b00_1101;
    localparam logic [5:0] op_xori    = 6'b00_1110;
    localparam logic [5:0] op_lui     = 6'b00_1111;
    localparam logic [5:0] op_sw      = 6'b10_1011;

    // funct codes under op_special
    localparam logic [5:0] fn_add  = 6'b10_0000;
    localparam logic [5:0] fn_addu = 6'b10_0001;
    localparam logic [5:0] fn_sub  = 6'b10_0010;
    localparam logic [5:0] fn_subu = 6'b10_0011;
    localparam logic [5:0] fn_and  = 6'b10_0100;
    localparam logic [5:0] fn_or   = 6'b10_0101;
    localparam logic [5:0] fn_xor  = 6'b10_0110;
    localparam logic [5:0] fn_nor  = 6'b10_0111;
    localparam logic [5:0] fn_slt  = 6'b10_1010;
    localparam logic [5:0] fn_sltu = 6'b10_1011;

    // r-format view of one instruction word, immediate is the low 16 bits
    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_pass_b
    } alu_op_e;

endpackage

`default_nettype wire

// File: fetch_unit.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_unit (
    input  logic            clk,
    input  logic            rst,
    output logic            ibus_cyc,
    output logic            ibus_stb,
    output mips_pkg::word_t ibus_adr,
    input  mips_pkg::word_t ibus_dat,
    input  logic            ibus_ack,
    output logic            out_valid,
    output mips_pkg::word_t out_instr,
    input  logic            out_ready
);

    mips_pkg::word_t pc;
    logic            busy;

    // one bus cycle at a time, started only while the queue has room
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (busy) begin
            if (ibus_ack) begin
                busy <= 1'b0;
            end
        end else if (out_ready) begin
            busy <= 1'b1;
        end
    end

    // sequential fetch only
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else if (busy && ibus_ack) begin
            pc <= pc + mips_pkg::xlen'(4);
        end
    end

    // cyc and stb move together, address held from pc until ack
    assign ibus_cyc = busy;
    assign ibus_stb = busy;
    assign ibus_adr = pc;

    // the acked word is pushed on the ack edge itself
    // queue cannot fill while a read is open, so the push always lands
    assign out_valid = busy & ibus_ack;
    assign out_instr = ibus_dat;

endmodule

`default_nettype wire

// File: instr_queue.sv
`default_nettype none
`timescale 1ns/1ps

module instr_queue (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  mips_pkg::word_t in_instr,
    output logic            in_ready,
    output logic            out_valid,
    output mips_pkg::word_t out_instr,
    input  logic            out_ready
);

    typedef logic [$clog2(mips_pkg::queue_depth)-1:0]   ptr_t;
    typedef logic [$clog2(mips_pkg::queue_depth+1)-1:0] cnt_t;

    logic [mips_pkg::xlen-1:0] mem [mips_pkg::queue_depth];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;
    logic full;
    logic empty;
    logic push;
    logic pop;

    assign full  = (count == cnt_t'(mips_pkg::queue_depth));
    assign empty = (count == '0);
    assign push  = in_valid & ~full;
    assign pop   = out_ready & ~empty;

    assign in_ready  = ~full;
    assign out_valid = ~empty;
    assign out_instr = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_instr;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_t'(mips_pkg::queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(mips_pkg::queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: reg_file.sv
`default_nettype none
`timescale 1ns/1ps

module reg_file (
    input  logic                clk,
    input  logic                rst,
    input  mips_pkg::reg_addr_t rd_addr_a,
    input  mips_pkg::reg_addr_t rd_addr_b,
    output mips_pkg::word_t     rd_data_a,
    output mips_pkg::word_t     rd_data_b,
    input  logic                wr_en,
    input  mips_pkg::reg_addr_t wr_addr,
    input  mips_pkg::word_t     wr_data
);

    mips_pkg::word_t regs [mips_pkg::num_regs];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < mips_pkg::num_regs; i++) begin
                regs[i] <= {mips_pkg::xlen{1'b0}};
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // $zero reads as zero
    assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

`default_nettype wire

// File: alu.sv
`default_nettype none
`timescale 1ns/1ps

module alu (
    input  mips_pkg::word_t   op_a,
    input  mips_pkg::word_t   op_b,
    input  mips_pkg::alu_op_e op,
    output mips_pkg::word_t   result,
    output logic              overflow
);

    mips_pkg::word_t sum;
    mips_pkg::word_t diff;
    logic            add_ovf;
    logic            sub_ovf;

    assign sum  = op_a + op_b;
    assign diff = op_a - op_b;

    // same signs in, different sign out
    assign add_ovf = (op_a[mips_pkg::xlen-1] == op_b[mips_pkg::xlen-1])
                   && (sum[mips_pkg::xlen-1] != op_a[mips_pkg::xlen-1]);
    // opposite signs in, result sign flipped from a
    assign sub_ovf = (op_a[mips_pkg::xlen-1] != op_b[mips_pkg::xlen-1])
                   && (diff[mips_pkg::xlen-1] != op_a[mips_pkg::xlen-1]);

    always_comb begin
        result   = '0;
        overflow = 1'b0;
        case (op)
            mips_pkg::alu_add: begin
                result   = sum;
                overflow = add_ovf;
            end
            mips_pkg::alu_sub: begin
                result   = diff;
                overflow = sub_ovf;
            end
            mips_pkg::alu_slt:    result = mips_pkg::word_t'($signed(op_a) < $signed(op_b));
            mips_pkg::alu_sltu:   result = mips_pkg::word_t'(op_a < op_b);
            mips_pkg::alu_and:    result = op_a & op_b;
            mips_pkg::alu_or:     result = op_a | op_b;
            mips_pkg::alu_xor:    result = op_a ^ op_b;
            mips_pkg::alu_nor:    result = ~(op_a | op_b);
            mips_pkg::alu_pass_b: result = op_b;
            default:              result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: exec_core.sv
`default_nettype none
`timescale 1ns/1ps

module exec_core (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  mips_pkg::word_t in_instr,
    output logic            in_ready,
    output logic            dbus_cyc,
    output logic            dbus_stb,
    output mips_pkg::word_t dbus_adr,
    output mips_pkg::word_t dbus_dat,
    input  logic            dbus_ack,
    output logic            integer_overflow
);

    typedef enum logic [2:0] {
        st_idle,
        st_decode,
        st_execute,
        st_writeback,
        st_store
    } state_e;

    typedef enum logic [1:0] {
        ext_sign,
        ext_zero,
        ext_upper
    } ext_e;

    state_e              state;
    mips_pkg::instr_t    ir;
    logic                pop;
    logic [15:0]         imm16;
    mips_pkg::word_t     imm_ext;
    mips_pkg::word_t     rs_data;
    mips_pkg::word_t     rt_data;
    // decode results, valid in st_decode
    logic                is_alu;
    logic                is_sw;
    logic                use_imm;
    logic                ovf_check_d;
    ext_e                ext_mode;
    mips_pkg::alu_op_e   alu_op_d;
    mips_pkg::reg_addr_t dest_d;
    // held from decode through writeback
    mips_pkg::alu_op_e   alu_op_q;
    mips_pkg::reg_addr_t dest_q;
    logic                ovf_check_q;
    logic                ovf_q;
    mips_pkg::word_t     op_a_q;
    mips_pkg::word_t     op_b_q;
    mips_pkg::word_t     store_data_q;
    mips_pkg::word_t     result_q;
    mips_pkg::word_t     alu_result;
    logic                alu_overflow;
    logic                wb_blocked;

    // a new word is taken in idle or on the writeback edge
    assign in_ready = (state == st_idle) || (state == st_writeback);
    assign pop      = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (pop) begin
            ir <= mips_pkg::instr_t'(in_instr);
        end
    end

    assign imm16 = ir[15:0];

    always_comb begin
        is_alu      = 1'b0;
        is_sw       = 1'b0;
        use_imm     = 1'b1;
        ovf_check_d = 1'b0;
        ext_mode    = ext_sign;
        alu_op_d    = mips_pkg::alu_add;
        dest_d      = ir.rt;
        case (ir.opcode)
            mips_pkg::op_special: begin
                is_alu  = 1'b1;
                use_imm = 1'b0;
                dest_d  = ir.rd;
                case (ir.funct)
                    mips_pkg::fn_add: begin
                        alu_op_d    = mips_pkg::alu_add;
                        ovf_check_d = 1'b1;
                    end
                    mips_pkg::fn_sub: begin
                        alu_op_d    = mips_pkg::alu_sub;
                        ovf_check_d = 1'b1;
                    end
                    mips_pkg::fn_addu: alu_op_d = mips_pkg::alu_add;
                    mips_pkg::fn_subu: alu_op_d = mips_pkg::alu_sub;
                    mips_pkg::fn_slt:  alu_op_d = mips_pkg::alu_slt;
                    mips_pkg::fn_sltu: alu_op_d = mips_pkg::alu_sltu;
                    mips_pkg::fn_and:  alu_op_d = mips_pkg::alu_and;
                    mips_pkg::fn_or:   alu_op_d = mips_pkg::alu_or;
                    mips_pkg::fn_xor:  alu_op_d = mips_pkg::alu_xor;
                    mips_pkg::fn_nor:  alu_op_d = mips_pkg::alu_nor;
                    default:           is_alu = 1'b0;
                endcase
            end
            mips_pkg::op_addi: begin
                is_alu      = 1'b1;
                ovf_check_d = 1'b1;
            end
            mips_pkg::op_addiu: is_alu = 1'b1;
            mips_pkg::op_slti: begin
                is_alu   = 1'b1;
                alu_op_d = mips_pkg::alu_slt;
            end
            // sltiu still sign-extends, then compares unsigned
            mips_pkg::op_sltiu: begin
                is_alu   = 1'b1;
                alu_op_d = mips_pkg::alu_sltu;
            end
            mips_pkg::op_andi: begin
                is_alu   = 1'b1;
                ext_mode = ext_zero;
                alu_op_d = mips_pkg::alu_and;
            end
            mips_pkg::op_ori: begin
                is_alu   = 1'b1;
                ext_mode = ext_zero;
                alu_op_d = mips_pkg::alu_or;
            end
            mips_pkg::op_xori: begin
                is_alu   = 1'b1;
                ext_mode = ext_zero;
                alu_op_d = mips_pkg::alu_xor;
            end
            mips_pkg::op_lui: begin
                is_alu   = 1'b1;
                ext_mode = ext_upper;
                alu_op_d = mips_pkg::alu_pass_b;
            end
            // address is rs plus sign-extended offset through the alu adder
            mips_pkg::op_sw: is_sw = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        case (ext_mode)
            ext_zero:  imm_ext = {{(mips_pkg::xlen-16){1'b0}}, imm16};
            ext_upper: imm_ext = {imm16, {(mips_pkg::xlen-16){1'b0}}};
            default:   imm_ext = {{(mips_pkg::xlen-16){imm16[15]}}, imm16};
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (in_valid) begin
                        state <= st_decode;
                    end
                end
                // unsupported words fall back to idle here
                st_decode: begin
                    if (is_alu) begin
                        state <= st_execute;
                    end else if (is_sw) begin
                        state <= st_store;
                    end else begin
                        state <= st_idle;
                    end
                end
                st_execute:   state <= st_writeback;
                st_writeback: state <= in_valid ? st_decode : st_idle;
                st_store: begin
                    if (dbus_ack) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            alu_op_q    <= mips_pkg::alu_add;
            dest_q      <= '0;
            ovf_check_q <= 1'b0;
            ovf_q       <= 1'b0;
        end else begin
            if (state == st_decode) begin
                alu_op_q    <= alu_op_d;
                dest_q      <= dest_d;
                ovf_check_q <= ovf_check_d;
            end
            if (state == st_execute) begin
                ovf_q <= alu_overflow;
            end
        end
    end

    // operands latched at the end of decode, result at the end of execute
    always_ff @(posedge clk) begin
        if (state == st_decode) begin
            op_a_q       <= rs_data;
            op_b_q       <= use_imm ? imm_ext : rt_data;
            store_data_q <= rt_data;
        end
        if (state == st_execute) begin
            result_q <= alu_result;
        end
    end

    reg_file i_reg_file (
        .clk       (clk),
        .rst       (rst),
        .rd_addr_a (ir.rs),
        .rd_addr_b (ir.rt),
        .rd_data_a (rs_data),
        .rd_data_b (rt_data),
        .wr_en     ((state == st_writeback) && !wb_blocked),
        .wr_addr   (dest_q),
        .wr_data   (result_q)
    );

    alu i_alu (
        .op_a     (op_a_q),
        .op_b     (op_b_q),
        .op       (alu_op_q),
        .result   (alu_result),
        .overflow (alu_overflow)
    );

    // trapping add, addi or sub leaves the destination untouched
    assign wb_blocked       = ovf_check_q & ovf_q;
    assign integer_overflow = (state == st_writeback) && wb_blocked;

    // store cycle held open until the slave acks
    assign dbus_cyc = (state == st_store);
    assign dbus_stb = (state == st_store);
    assign dbus_adr = alu_result;
    assign dbus_dat = store_data_q;

endmodule

`default_nettype wire

// File: mips_top.sv
`default_nettype none
`timescale 1ns/1ps

module mips_top (
    input  logic                      clk,
    input  logic                      rst,
    output logic                      ibus_cyc,
    output logic                      ibus_stb,
    output logic [mips_pkg::xlen-1:0] ibus_adr,
    input  logic [mips_pkg::xlen-1:0] ibus_dat,
    input  logic                      ibus_ack,
    output logic                      dbus_cyc,
    output logic                      dbus_stb,
    output logic [mips_pkg::xlen-1:0] dbus_adr,
    output logic [mips_pkg::xlen-1:0] dbus_dat,
    input  logic                      dbus_ack,
    output logic                      integer_overflow
);

    // fetch to queue
    logic            fq_valid;
    logic            fq_ready;
    mips_pkg::word_t fq_instr;
    // queue to core
    logic            qc_valid;
    logic            qc_ready;
    mips_pkg::word_t qc_instr;

    fetch_unit i_fetch_unit (
        .clk       (clk),
        .rst       (rst),
        .ibus_cyc  (ibus_cyc),
        .ibus_stb  (ibus_stb),
        .ibus_adr  (ibus_adr),
        .ibus_dat  (ibus_dat),
        .ibus_ack  (ibus_ack),
        .out_valid (fq_valid),
        .out_instr (fq_instr),
        .out_ready (fq_ready)
    );

    instr_queue i_instr_queue (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (fq_valid),
        .in_instr  (fq_instr),
        .in_ready  (fq_ready),
        .out_valid (qc_valid),
        .out_instr (qc_instr),
        .out_ready (qc_ready)
    );

    exec_core i_exec_core (
        .clk              (clk),
        .rst              (rst),
        .in_valid         (qc_valid),
        .in_instr         (qc_instr),
        .in_ready         (qc_ready),
        .dbus_cyc         (dbus_cyc),
        .dbus_stb         (dbus_stb),
        .dbus_adr         (dbus_adr),
        .dbus_dat         (dbus_dat),
        .dbus_ack         (dbus_ack),
        .integer_overflow (integer_overflow)
    );

endmodule

`default_nettype wire

// File: tb_mips.sv
`default_nettype none
`timescale 1ns/1ps

module tb_mips;

    localparam int prog_len   = 200;
    localparam int clk_period = 8;
    localparam int max_cycles = prog_len * 12;

    logic        clk;
    logic        rst;
    logic        ibus_cyc;
    logic        ibus_stb;
    logic [31:0] ibus_adr;
    logic [31:0] ibus_dat;
    logic        ibus_ack;
    logic        dbus_cyc;
    logic        dbus_stb;
    logic [31:0] dbus_adr;
    logic [31:0] dbus_dat;
    logic        dbus_ack;
    logic        integer_overflow;

    logic [31:0] prog [prog_len];
    logic [31:0] model_regs [32];
    logic [5:0]  fn_list [10];
    logic [5:0]  imm_ops [8];

    // kind 0 marks a store and kind 1 an overflow
    int          exp_kind [$];
    logic [31:0] exp_adr [$];
    logic [31:0] exp_dat [$];
    int          ev_idx;
    logic [31:0] fetch_adr;
    int          stall_reads;
    int          ibus_wait;
    int          dbus_wait;
    int          store_count;

    mips_top i_mips_top (
        .clk              (clk),
        .rst              (rst),
        .ibus_cyc         (ibus_cyc),
        .ibus_stb         (ibus_stb),
        .ibus_adr         (ibus_adr),
        .ibus_dat         (ibus_dat),
        .ibus_ack         (ibus_ack),
        .dbus_cyc         (dbus_cyc),
        .dbus_stb         (dbus_stb),
        .dbus_adr         (dbus_adr),
        .dbus_dat         (dbus_dat),
        .dbus_ack         (dbus_ack),
        .integer_overflow (integer_overflow)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic logic [31:0] enc_r(int rs, int rt, int rd, logic [5:0] fn);
        return {mips_pkg::op_special, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic logic [31:0] enc_i(logic [5:0] op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [31:0] sext16(logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic logic [31:0] zext16(logic [15:0] imm);
        return {16'h0000, imm};
    endfunction

    // true when the signed 32-bit result does not fit
    function automatic logic out_of_range(longint v);
        return (v > 64'sd2147483647) || (v < -64'sd2147483648);
    endfunction

    task automatic set_reg(int idx, logic [31:0] val);
        if (idx != 0) begin
            model_regs[idx] = val;
        end
    endtask

    task automatic add_overflow_event();
        exp_kind.push_back(1);
        exp_adr.push_back(32'h0);
        exp_dat.push_back(32'h0);
    endtask

    task automatic build_program();
        int sel;
        for (int r = 1; r < 8; r++) begin
            prog[2*r-2] = enc_i(mips_pkg::op_lui, 0, r, 16'($urandom));
            prog[2*r-1] = enc_i(mips_pkg::op_ori, r, r, 16'($urandom));
        end
        for (int i = 14; i < prog_len - 7; i++) begin
            sel = $urandom % 20;
            if (i % 5 == 4) begin
                prog[i] = enc_i(mips_pkg::op_sw, $urandom % 8, $urandom % 8, 16'($urandom));
            end else if (sel < 10) begin
                prog[i] = enc_r($urandom % 8, $urandom % 8, $urandom % 8,
                                fn_list[$urandom % 10]);
            end else if (sel < 15) begin
                prog[i] = enc_i(imm_ops[$urandom % 8], $urandom % 8, $urandom % 8,
                                16'($urandom));
            end else if (sel < 17) begin
                // large positive values push later adds over the edge
                prog[i] = enc_i(mips_pkg::op_lui, 0, 1 + $urandom % 7,
                                16'h7ff0 | 16'($urandom % 16));
            end else if (sel < 19) begin
                prog[i] = enc_i(mips_pkg::op_addi, $urandom % 8, 1 + $urandom % 7, 16'h7fff);
            end else begin
                // opcode 0x3f is outside the subset
                prog[i] = {6'h3f, 26'($urandom)};
            end
        end
        for (int r = 1; r < 8; r++) begin
            prog[prog_len - 8 + r] = enc_i(mips_pkg::op_sw, 0, r, 16'(r * 4));
        end
    endtask

    task automatic run_model();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [15:0] imm;
        longint      s;
        int          rs;
        int          rt;
        int          rd;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = 32'h0;
        end
        for (int i = 0; i < prog_len; i++) begin
            w   = prog[i];
            rs  = int'(w[25:21]);
            rt  = int'(w[20:16]);
            rd  = int'(w[15:11]);
            imm = w[15:0];
            a   = model_regs[rs];
            b   = model_regs[rt];
            case (w[31:26])
                mips_pkg::op_special: begin
                    case (w[5:0])
                        mips_pkg::fn_add: begin
                            s = longint'($signed(a)) + longint'($signed(b));
                            if (out_of_range(s)) add_overflow_event();
                            else set_reg(rd, a + b);
                        end
                        mips_pkg::fn_sub: begin
                            s = longint'($signed(a)) - longint'($signed(b));
                            if (out_of_range(s)) add_overflow_event();
                            else set_reg(rd, a - b);
                        end
                        mips_pkg::fn_addu: set_reg(rd, a + b);
                        mips_pkg::fn_subu: set_reg(rd, a - b);
                        mips_pkg::fn_slt:  set_reg(rd, {31'h0, $signed(a) < $signed(b)});
                        mips_pkg::fn_sltu: set_reg(rd, {31'h0, a < b});
                        mips_pkg::fn_and:  set_reg(rd, a & b);
                        mips_pkg::fn_or:   set_reg(rd, a | b);
                        mips_pkg::fn_xor:  set_reg(rd, a ^ b);
                        mips_pkg::fn_nor:  set_reg(rd, ~(a | b));
                        default: ;
                    endcase
                end
                mips_pkg::op_addi: begin
                    s = longint'($signed(a)) + longint'($signed(sext16(imm)));
                    if (out_of_range(s)) add_overflow_event();
                    else set_reg(rt, a + sext16(imm));
                end
                mips_pkg::op_addiu: set_reg(rt, a + sext16(imm));
                mips_pkg::op_slti:  set_reg(rt, {31'h0, $signed(a) < $signed(sext16(imm))});
                mips_pkg::op_sltiu: set_reg(rt, {31'h0, a < sext16(imm)});
                mips_pkg::op_andi:  set_reg(rt, a & zext16(imm));
                mips_pkg::op_ori:   set_reg(rt, a | zext16(imm));
                mips_pkg::op_xori:  set_reg(rt, a ^ zext16(imm));
                mips_pkg::op_lui:   set_reg(rt, {imm, 16'h0000});
                mips_pkg::op_sw: begin
                    exp_kind.push_back(0);
                    exp_adr.push_back(a + sext16(imm));
                    exp_dat.push_back(b);
                end
                default: ;
            endcase
        end
    endtask

    // zero past the end of the program decodes as a no-op
    function automatic logic [31:0] program_word(logic [31:0] adr);
        if ((adr >> 2) < prog_len) begin
            return prog[adr >> 2];
        end
        return 32'h0;
    endfunction

    initial begin
        void'($urandom(79));
        rst      = 1'b1;
        ibus_dat = 32'h0;
        ibus_ack = 1'b0;
        dbus_ack = 1'b0;
        fn_list  = '{mips_pkg::fn_add, mips_pkg::fn_addu, mips_pkg::fn_sub, mips_pkg::fn_subu,
                     mips_pkg::fn_slt, mips_pkg::fn_sltu, mips_pkg::fn_and, mips_pkg::fn_or,
                     mips_pkg::fn_xor, mips_pkg::fn_nor};
        imm_ops  = '{mips_pkg::op_addi, mips_pkg::op_addiu, mips_pkg::op_slti,
                     mips_pkg::op_sltiu, mips_pkg::op_andi, mips_pkg::op_ori,
                     mips_pkg::op_xori, mips_pkg::op_lui};
        build_program();
        run_model();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        wait (ev_idx == exp_kind.size());
        // extra events in this tail fail in the monitor
        repeat (40) @(posedge clk);
        $display("TESTS PASSED");
        $finish;
    end

    initial begin
        #(max_cycles * clk_period);
        $display("timeout: the expected stores and overflow pulses did not all arrive");
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    // instruction memory with 0 to 3 wait cycles
    always @(posedge clk) begin
        if (rst) begin
            ibus_ack  <= 1'b0;
            ibus_wait <= 0;
        end else begin
            ibus_ack <= 1'b0;
            if (ibus_cyc && ibus_stb && !ibus_ack) begin
                if (ibus_wait == 0) begin
                    ibus_ack  <= 1'b1;
                    ibus_dat  <= program_word(ibus_adr);
                    ibus_wait <= $urandom % 4;
                end else begin
                    ibus_wait <= ibus_wait - 1;
                end
            end
        end
    end

    // store slave holds every sixth store off for a long stall
    always @(posedge clk) begin
        if (rst) begin
            dbus_ack    <= 1'b0;
            dbus_wait   <= 0;
            store_count <= 0;
        end else begin
            dbus_ack <= 1'b0;
            if (dbus_cyc && dbus_stb && !dbus_ack) begin
                if (dbus_wait == 0) begin
                    dbus_ack    <= 1'b1;
                    store_count <= store_count + 1;
                    dbus_wait   <= ((store_count % 6) == 2) ? 30 : int'($urandom % 4);
                end else begin
                    dbus_wait <= dbus_wait - 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            ev_idx      <= 0;
            fetch_adr   <= 32'h0;
            stall_reads <= 0;
            assert (!ibus_cyc && !ibus_stb) else
                report_failure($sformatf("error: ibus_cyc=%h ibus_stb=%h in reset, expected 0",
                                         ibus_cyc, ibus_stb));
            assert (!dbus_cyc && !dbus_stb) else
                report_failure($sformatf("error: dbus_cyc=%h dbus_stb=%h in reset, expected 0",
                                         dbus_cyc, dbus_stb));
            assert (!integer_overflow) else
                report_failure($sformatf("error: integer_overflow=%h in reset, expected 0",
                                         integer_overflow));
        end else begin
            assert (ibus_stb == ibus_cyc) else
                report_failure($sformatf("error: ibus_stb got %h expected %h",
                                         ibus_stb, ibus_cyc));
            assert (dbus_stb == dbus_cyc) else
                report_failure($sformatf("error: dbus_stb got %h expected %h",
                                         dbus_stb, dbus_cyc));
            // address holds from the start of a read until its ack
            if (ibus_cyc) begin
                assert (ibus_adr == fetch_adr) else
                    report_failure($sformatf("error: ibus_adr got %h expected %h",
                                             ibus_adr, fetch_adr));
            end
            if (ibus_cyc && ibus_ack) begin
                fetch_adr <= fetch_adr + 32'd4;
            end
            // reads while a store waits must fit in the queue
            if (!dbus_cyc) begin
                stall_reads <= 0;
            end else if (ibus_cyc && ibus_ack) begin
                stall_reads <= stall_reads + 1;
                assert (stall_reads < mips_pkg::queue_depth) else
                    report_failure("fetch kept reading while the store bus was stalled");
            end
            if (dbus_cyc && dbus_ack) begin
                assert (ev_idx < exp_kind.size() && exp_kind[ev_idx] == 0) else
                    report_failure($sformatf("error: unexpected store, dbus_adr=%h dbus_dat=%h",
                                             dbus_adr, dbus_dat));
                assert (dbus_adr == exp_adr[ev_idx]) else
                    report_failure($sformatf("error: dbus_adr got %h expected %h",
                                             dbus_adr, exp_adr[ev_idx]));
                assert (dbus_dat == exp_dat[ev_idx]) else
                    report_failure($sformatf("error: dbus_dat got %h expected %h",
                                             dbus_dat, exp_dat[ev_idx]));
                ev_idx <= ev_idx + 1;
            end
            if (integer_overflow) begin
                assert (ev_idx < exp_kind.size() && exp_kind[ev_idx] == 1) else
                    report_failure($sformatf("error: integer_overflow pulse %h not expected here",
                                             integer_overflow));
                ev_idx <= ev_idx + 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: sim.f
mips_pkg.sv
fetch_unit.sv
instr_queue.sv
reg_file.sv
alu.sv
exec_core.sv
mips_top.sv
tb_mips.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_mips
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
